// File: verilog.f
logic/led_pkg.sv
logic/rate_pkg.sv
logic/rate_counter.sv
logic/cylon_scanner.sv
logic/error_pattern.sv
logic/pulse_stretcher.sv
logic/heartbeat_divider.sv
logic/led_control.sv
verification/led_control_chk.sv
verification/tb_led_control.sv

// File: Makefile
# Verilator build and run for the LED controller testbench

VERILATOR ?= verilator
TOP       ?= tb_led_control
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
FAIL_MSG  ?= Simulation FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, scan $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exit status $$status"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_led_control.sv
`timescale 1ns/100ps
`default_nettype none

module tb_led_control
  import rate_pkg::*;
  import led_pkg::*;
();

  // Small DUT settings so windows and blinks fit a short run
  localparam int CLK_FREQUENCY  = 1024;
  localparam int SPEEDUP_FACTOR = 4;
  localparam int BAR_STEP       = 2048;
  localparam int BLINK_WIDTH    = 4;
  localparam int CYLON_DIV      = 2;
  localparam int ERR_DIV        = 3;
  localparam int FLASH_CYCLES   = 10;

  // 64 cycles per rate window
  localparam int WINDOW = CLK_FREQUENCY >> SPEEDUP_FACTOR;

  // Status LED positions on the panel
  localparam int FLASH_BIT = 12;
  localparam int CLK_BIT   = 13;
  localparam int ECLK_BIT  = 14;
  localparam int LINK_BIT  = 15;

  // Test lengths in clock cycles
  localparam int RESET_CYCLES = 16;
  localparam int ERR_CYCLES   = 80;
  localparam int CYLON_CYCLES = 120;
  localparam int RATE_HOLD    = 3 * WINDOW;
  localparam int RATE_SETTLE  = 8;
  localparam int NUM_STEPS    = 5;
  localparam int FLASH_WINDOW = 40;
  localparam int BEAT_CYCLES  = 200;
  localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + ERR_CYCLES + CYLON_CYCLES + 3
                              + (1 + NUM_STEPS) * (RATE_HOLD + RATE_SETTLE + 1)
                              + 2 * FLASH_WINDOW + 4 * 2 + BEAT_CYCLES;
  localparam int CYCLE_LIMIT  = 2 * TOTAL_CYCLES;

  logic                 clock;
  logic                 gbt_eclk;
  logic                 reset;
  logic                 mmcm_locked;
  logic                 gbt_rxready;
  logic                 gbt_rxvalid;
  logic                 gbt_request_received;
  increment_t           cluster_count;
  rate_t                cluster_rate;
  logic [LED_WIDTH-1:0] led_out;

  logic [31:0] lcg_state;
  int          check_count;
  int          error_count;
  int          cycle_count;

  led_control #(
    .CLK_FREQUENCY  (CLK_FREQUENCY),
    .SPEEDUP_FACTOR (SPEEDUP_FACTOR),
    .BAR_STEP       (BAR_STEP),
    .BLINK_WIDTH    (BLINK_WIDTH),
    .CYLON_DIV      (CYLON_DIV),
    .ERR_DIV        (ERR_DIV),
    .FLASH_CYCLES   (FLASH_CYCLES)
  ) u_dut (
    .clock                (clock),
    .reset                (reset),
    .mmcm_locked          (mmcm_locked),
    .gbt_eclk             (gbt_eclk),
    .gbt_rxready          (gbt_rxready),
    .gbt_rxvalid          (gbt_rxvalid),
    .gbt_request_received (gbt_request_received),
    .cluster_count        (cluster_count),
    .cluster_rate         (cluster_rate),
    .led_out              (led_out)
  );

  // ----------------------------------------
  // Clocks and watchdog
  // ----------------------------------------

  // System clock with an 8 ns period
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Elink clock with a 10 ns period and unrelated phase
  initial begin
    gbt_eclk = 1'b0;
    forever #5 gbt_eclk = ~gbt_eclk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: run still going after %0d clock cycles", CYCLE_LIMIT);
    $display("Simulation FAILED");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Lit LEDs for a rate with one per BAR_STEP up to the bar width
  function automatic logic [BAR_WIDTH-1:0] thermometer(input rate_t rate);
    rate_t levels;
    levels = rate / rate_t'(BAR_STEP);
    if (levels > rate_t'(BAR_WIDTH)) begin
      levels = rate_t'(BAR_WIDTH);
    end
    return BAR_WIDTH'((rate_t'(1) << levels) - rate_t'(1));
  endfunction

  // Index of the highest lit bit or -1 when dark
  function automatic int lit_position(input logic [BAR_WIDTH-1:0] leds);
    int pos;
    pos = -1;
    for (int i = 0; i < BAR_WIDTH; i++) begin
      if (leds[i]) begin
        pos = i;
      end
    end
    return pos;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0d ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  // Pass or fail of a condition with no single expected value
  task automatic require(input logic ok, input string what);
    check_count++;
    if (ok !== 1'b1) begin
      error_count++;
      $display("error at %0d ns: %s", $time, what);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s finished with %0d errors", name, error_count - errors_before);
  endtask

  // Holds one count for three windows and then checks rate and bar
  task automatic hold_and_check(input increment_t value);
    rate_t                expected_rate;
    logic [BAR_WIDTH-1:0] expected_bar;
    expected_rate = (rate_t'(value) * rate_t'(WINDOW)) << SPEEDUP_FACTOR;
    expected_bar  = thermometer(expected_rate);
    @(posedge clock);
    cluster_count <= value;
    repeat (RATE_HOLD) @(posedge clock);
    // Bar must hold still with no scanning left
    repeat (RATE_SETTLE) begin
      @(negedge clock);
      check("cluster_rate", expected_rate, cluster_rate);
      check("led_out[11:0]", 32'(expected_bar), 32'(led_out[BAR_WIDTH-1:0]));
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic verify_reset_values();
    int errors_before;
    errors_before = error_count;
    @(negedge clock);
    check("led_out", 0, 32'(led_out));
    check("cluster_rate", 0, cluster_rate);
    report_test("reset values", errors_before);
  endtask

  task automatic watch_error_mode();
    int   errors_before;
    logic saw_low;
    logic saw_high;
    logic legal;
    errors_before = error_count;
    saw_low  = 1'b0;
    saw_high = 1'b0;
    repeat (ERR_CYCLES) begin
      @(negedge clock);
      legal = (led_out == 16'h00ff) || (led_out == 16'hff00);
      require(legal, $sformatf("led_out 0x%04h is neither half-panel pattern", led_out));
      if (led_out == 16'h00ff) begin
        saw_low = 1'b1;
      end
      if (led_out == 16'hff00) begin
        saw_high = 1'b1;
      end
    end
    require(saw_low, "low half pattern 0x00ff never appeared");
    require(saw_high, "high half pattern 0xff00 never appeared");
    report_test("error mode", errors_before);
  endtask

  task automatic follow_cylon_scan();
    int   errors_before;
    int   pos;
    int   prev_pos;
    int   distance;
    logic saw_bottom;
    logic saw_top;
    errors_before = error_count;
    saw_bottom = 1'b0;
    saw_top    = 1'b0;
    prev_pos   = -1;
    @(posedge clock);
    mmcm_locked <= 1'b1;
    // Lock seen and then one more cycle through the LED register
    repeat (2) @(posedge clock);
    repeat (CYLON_CYCLES) begin
      @(negedge clock);
      require($onehot(led_out[BAR_WIDTH-1:0]),
              $sformatf("led_out[11:0] 0x%03h is not one-hot", led_out[BAR_WIDTH-1:0]));
      pos = lit_position(led_out[BAR_WIDTH-1:0]);
      if (prev_pos >= 0 && pos != prev_pos) begin
        distance = (pos > prev_pos) ? pos - prev_pos : prev_pos - pos;
        require(distance == 1, $sformatf("scan jumped %0d places in one step", distance));
      end
      saw_bottom = saw_bottom | (pos == 0);
      saw_top    = saw_top | (pos == BAR_WIDTH - 1);
      prev_pos   = pos;
    end
    require(saw_bottom, "scan never reached bit 0");
    require(saw_top, "scan never reached bit 11");
    report_test("cylon", errors_before);
  endtask

  task automatic measure_constant_rate();
    int         errors_before;
    increment_t value;
    errors_before = error_count;
    lcg_state = lcg_next(lcg_state);
    // Nonzero so the first-cluster flag gets set
    value = increment_t'((lcg_state[23:16] % 8'd255) + 8'd1);
    hold_and_check(value);
    report_test("constant rate", errors_before);
  endtask

  task automatic step_through_rates();
    int         errors_before;
    int         n;
    increment_t steps [NUM_STEPS];
    errors_before = error_count;
    for (n = 0; n < NUM_STEPS; n++) begin
      lcg_state = lcg_next(lcg_state);
      steps[n]  = increment_t'(lcg_state[23:16]);
    end
    // Idle and saturating corners between random values
    steps[1] = '0;
    steps[3] = '1;
    for (n = 0; n < NUM_STEPS; n++) begin
      hold_and_check(steps[n]);
    end
    report_test("rate steps", errors_before);
  endtask

  // Second pulse at cycle second_at or none when zero
  task automatic run_flash(input int second_at, input string name);
    int i;
    int first_lit;
    int last_lit;
    int lit_count;
    int expected_last;
    first_lit     = -1;
    last_lit      = -1;
    lit_count     = 0;
    expected_last = (second_at > 0) ? second_at + FLASH_CYCLES + 1 : FLASH_CYCLES + 1;
    for (i = 0; i < FLASH_WINDOW; i++) begin
      @(posedge clock);
      gbt_request_received <= (i == 0) || (i == second_at);
      @(negedge clock);
      if (led_out[FLASH_BIT]) begin
        if (first_lit < 0) begin
          first_lit = i;
        end
        last_lit = i;
        lit_count++;
      end
    end
    check({name, " first lit cycle"}, 2, 32'(first_lit));
    check({name, " last lit cycle"}, 32'(expected_last), 32'(last_lit));
    check({name, " lit cycles"}, 32'(expected_last - 1), 32'(lit_count));
  endtask

  task automatic pulse_request_flash();
    int errors_before;
    errors_before = error_count;
    run_flash(0, "single flash");
    run_flash(5, "retriggered flash");
    report_test("flash", errors_before);
  endtask

  task automatic observe_status_bits();
    int   errors_before;
    int   k;
    int   combo;
    int   clk_toggles;
    int   eclk_toggles;
    logic prev_link;
    logic link;
    logic prev_clk;
    logic prev_eclk;
    errors_before = error_count;
    prev_link = 1'b0;
    // Order 11, 10, 01, 00 so the LED rises and falls
    for (k = 0; k < 4; k++) begin
      combo = 3 - k;
      link  = combo[0] & combo[1];
      @(posedge clock);
      gbt_rxready <= combo[0];
      gbt_rxvalid <= combo[1];
      @(negedge clock);
      check("led_out[15] before update", 32'(prev_link), 32'(led_out[LINK_BIT]));
      @(negedge clock);
      check("led_out[15]", 32'(link), 32'(led_out[LINK_BIT]));
      prev_link = link;
    end
    clk_toggles  = 0;
    eclk_toggles = 0;
    prev_clk     = led_out[CLK_BIT];
    prev_eclk    = led_out[ECLK_BIT];
    repeat (BEAT_CYCLES) begin
      @(negedge clock);
      if (led_out[CLK_BIT] != prev_clk) begin
        clk_toggles++;
      end
      if (led_out[ECLK_BIT] != prev_eclk) begin
        eclk_toggles++;
      end
      prev_clk  = led_out[CLK_BIT];
      prev_eclk = led_out[ECLK_BIT];
    end
    require(clk_toggles >= 2, "clk heartbeat on led_out[13] toggled fewer than two times");
    require(eclk_toggles >= 2, "eclk heartbeat on led_out[14] toggled fewer than two times");
    report_test("status bits", errors_before);
  endtask

  // ----------------------------------------
  // Sequence
  // ----------------------------------------

  initial begin
    reset                = 1'b1;
    mmcm_locked          = 1'b0;
    gbt_rxready          = 1'b0;
    gbt_rxvalid          = 1'b0;
    gbt_request_received = 1'b0;
    cluster_count        = '0;
    lcg_state            = 32'h9063_d3b2;
    check_count          = 0;
    error_count          = 0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    verify_reset_values();
    watch_error_mode();
    follow_cylon_scan();
    measure_constant_rate();
    step_through_rates();
    pulse_request_flash();
    observe_status_bits();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/led_control_chk.sv
`timescale 1ns/100ps
`default_nettype none

module led_control_chk
  import led_pkg::*;
(
  input logic                 clock,
  input logic                 reset,
  input logic                 mmcm_locked,
  input logic [BAR_WIDTH-1:0] bar,
  input logic [BAR_WIDTH-1:0] scan,
  input led_word_u            err_pattern,
  input logic [LED_WIDTH-1:0] led_out
);

  logic [LED_WIDTH-1:0] err_raw;

  assign err_raw = err_pattern.raw;

  // Lit bits contiguous from bit 0
  bar_thermometer: assert property (@(posedge clock) disable iff (reset)
    (bar & (bar + 1'b1)) == '0)
    else $error("bar is not a thermometer code");

  // Exactly one LED in the scan
  scan_one_hot: assert property (@(posedge clock) disable iff (reset)
    $onehot(scan))
    else $error("scan is not one-hot");

  // Unlocked last cycle, so the register took the error pattern
  error_output: assert property (@(posedge clock) disable iff (reset)
    !$past(reset) && !$past(mmcm_locked) |-> led_out == $past(err_raw))
    else $error("led_out does not follow the error pattern while unlocked");

endmodule

bind led_control led_control_chk u_chk (
  .clock       (clock),
  .reset       (reset),
  .mmcm_locked (mmcm_locked),
  .bar         (bar),
  .scan        (scan),
  .err_pattern (err_pattern),
  .led_out     (led_out)
);

`default_nettype wire

// File: logic/led_control.sv
`timescale 1ns/100ps
`default_nettype none

module led_control
  import rate_pkg::*;
  import led_pkg::*;
#(
  parameter int CLK_FREQUENCY  = 40079000,
  parameter int SPEEDUP_FACTOR = 4,
  parameter int BAR_STEP       = 20000,
  parameter int BLINK_WIDTH    = 20,
  parameter int CYLON_DIV      = 21,
  parameter int ERR_DIV        = 24,
  parameter int FLASH_CYCLES   = 4000000
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 mmcm_locked,
  input  logic                 gbt_eclk,
  input  logic                 gbt_rxready,
  input  logic                 gbt_rxvalid,
  input  logic                 gbt_request_received,
  input  increment_t           cluster_count,
  output rate_t                cluster_rate,
  output logic [LED_WIDTH-1:0] led_out
);

  logic [BAR_WIDTH-1:0] bar;
  logic [BAR_WIDTH-1:0] scan;
  led_word_u            err_pattern;
  logic                 flash;
  logic                 clk_beat;
  logic                 eclk_beat;
  logic                 cluster_seen;
  led_word_u            logic_view;
  logic [LED_WIDTH-1:0] cylon_word;

  // ----------------------------------------
  // Display sources
  // ----------------------------------------

  rate_counter #(
    .CLK_FREQUENCY  (CLK_FREQUENCY),
    .SPEEDUP_FACTOR (SPEEDUP_FACTOR),
    .BAR_STEP       (BAR_STEP)
  ) u_rate_counter (
    .clock     (clock),
    .reset     (reset),
    .increment (cluster_count),
    .rate      (cluster_rate),
    .bar       (bar)
  );

  cylon_scanner #(
    .CYLON_DIV (CYLON_DIV)
  ) u_cylon_scanner (
    .clock (clock),
    .reset (reset),
    .scan  (scan)
  );

  // Runs only while the clock manager is unlocked
  error_pattern #(
    .ERR_DIV (ERR_DIV)
  ) u_error_pattern (
    .clock   (clock),
    .reset   (reset),
    .enable  (~mmcm_locked),
    .pattern (err_pattern)
  );

  // Makes the GBT request visible
  pulse_stretcher #(
    .FLASH_CYCLES (FLASH_CYCLES)
  ) u_pulse_stretcher (
    .clock (clock),
    .reset (reset),
    .pulse (gbt_request_received),
    .flash (flash)
  );

  // System clock heartbeat
  heartbeat_divider #(
    .BLINK_WIDTH (BLINK_WIDTH)
  ) u_clk_heartbeat (
    .clock (clock),
    .reset (reset),
    .beat  (clk_beat)
  );

  // Elink clock heartbeat, own domain
  heartbeat_divider #(
    .BLINK_WIDTH (BLINK_WIDTH)
  ) u_eclk_heartbeat (
    .clock (gbt_eclk),
    .reset (reset),
    .beat  (eclk_beat)
  );

  // ----------------------------------------
  // Mode selection
  // ----------------------------------------

  // Cylon runs until the first cluster of the run
  always_ff @(posedge clock) begin
    if (reset) begin
      cluster_seen <= 1'b0;
    end else if (cluster_count != '0) begin
      cluster_seen <= 1'b1;
    end
  end

  // Normal status display, filled by field
  always_comb begin
    logic_view.fields.link_ok   = gbt_rxready & gbt_rxvalid;
    logic_view.fields.eclk_beat = eclk_beat;
    logic_view.fields.clk_beat  = clk_beat;
    logic_view.fields.gbt_flash = flash;
    logic_view.fields.bar       = bar;
  end

  // Scan replaces only the bar, status LEDs stay live
  assign cylon_word = {logic_view.raw[LED_WIDTH-1:BAR_WIDTH], scan};

  // Loss of lock overrides everything
  always_ff @(posedge clock) begin
    if (reset) begin
      led_out <= '0;
    end else if (!mmcm_locked) begin
      led_out <= err_pattern.raw;
    end else if (!cluster_seen) begin
      led_out <= cylon_word;
    end else begin
      led_out <= logic_view.raw;
    end
  end

endmodule

`default_nettype wire

// File: logic/heartbeat_divider.sv
`timescale 1ns/100ps
`default_nettype none

module heartbeat_divider #(
  parameter int BLINK_WIDTH = 20
) (
  input  logic clock,
  input  logic reset,
  output logic beat
);

  logic                   reset_meta;
  logic                   reset_sync;
  logic [BLINK_WIDTH-1:0] count;

  // ----------------------------------------
  // Reset synchronizer
  // ----------------------------------------

  // Reset may come from another clock domain
  always_ff @(posedge clock) begin
    reset_meta <= reset;
    reset_sync <= reset_meta;
  end

  // ----------------------------------------
  // Divider
  // ----------------------------------------

  // Toggle on every wrap to zero
  // Full blink period is 2 * 2**BLINK_WIDTH cycles
  always_ff @(posedge clock) begin
    if (reset_sync) begin
      count <= '0;
      beat  <= 1'b0;
    end else begin
      count <= count + 1'b1;
      if (count == '0) begin
        beat <= ~beat;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/pulse_stretcher.sv
`timescale 1ns/100ps
`default_nettype none

module pulse_stretcher #(
  parameter int FLASH_CYCLES = 4000000
) (
  input  logic clock,
  input  logic reset,
  input  logic pulse,
  output logic flash
);

  // Wide enough to hold FLASH_CYCLES itself
  localparam int CNT_BITS = $clog2(FLASH_CYCLES + 1);

  localparam logic [CNT_BITS-1:0] RELOAD = CNT_BITS'(FLASH_CYCLES);

  logic [CNT_BITS-1:0] remaining;

  // ----------------------------------------
  // Down-counter
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      remaining <= '0;
    end else if (pulse) begin
      // Retrigger restarts the full flash
      remaining <= RELOAD;
    end else if (remaining != '0) begin
      remaining <= remaining - 1'b1;
    end
  end

  // Lit for exactly FLASH_CYCLES cycles after the last pulse
  assign flash = (remaining != '0);

endmodule

`default_nettype wire

// File: logic/error_pattern.sv
`timescale 1ns/100ps
`default_nettype none

module error_pattern
  import led_pkg::*;
#(
  parameter int ERR_DIV = 24
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      enable,
  output led_word_u pattern
);

  // Low byte lit, its inverse lights the high byte
  localparam logic [LED_WIDTH-1:0] LOW_HALF =
    {{(LED_WIDTH / 2){1'b0}}, {(LED_WIDTH / 2){1'b1}}};

  logic [ERR_DIV-1:0] prescale;

  always_ff @(posedge clock) begin
    if (reset) begin
      prescale    <= '0;
      pattern.raw <= LOW_HALF;
    end else if (enable) begin
      prescale <= prescale + 1'b1;
      // Swap halves each time the prescaler wraps
      if (&prescale) begin
        pattern.raw <= ~pattern.raw;
      end
    end else begin
      // Park on the low half while locked
      prescale    <= '0;
      pattern.raw <= LOW_HALF;
    end
  end

endmodule

`default_nettype wire

// File: logic/cylon_scanner.sv
`timescale 1ns/100ps
`default_nettype none

module cylon_scanner
  import led_pkg::*;
#(
  parameter int CYLON_DIV = 21
) (
  input  logic                 clock,
  input  logic                 reset,
  output logic [BAR_WIDTH-1:0] scan
);

  logic [CYLON_DIV-1:0] prescale;
  logic                 step;
  // Low means moving toward the MSB
  logic                 going_down;
  logic                 dir_next;

  // One step per 2**CYLON_DIV cycles
  assign step = &prescale;

  // Turn around at either end of the bar
  always_comb begin
    if (scan[BAR_WIDTH-1]) begin
      dir_next = 1'b1;
    end else if (scan[0]) begin
      dir_next = 1'b0;
    end else begin
      dir_next = going_down;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      prescale   <= '0;
      going_down <= 1'b0;
      scan       <= BAR_WIDTH'(1);
    end else begin
      prescale <= prescale + 1'b1;
      if (step) begin
        going_down <= dir_next;
        // Shift the single lit LED one place
        scan <= dir_next ? (scan >> 1) : (scan << 1);
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/rate_counter.sv
`timescale 1ns/100ps
`default_nettype none

module rate_counter
  import rate_pkg::*;
  import led_pkg::*;
#(
  parameter int CLK_FREQUENCY  = 40079000,
  parameter int SPEEDUP_FACTOR = 4,
  parameter int BAR_STEP       = 20000
) (
  input  logic                 clock,
  input  logic                 reset,
  input  increment_t           increment,
  output rate_t                rate,
  output logic [BAR_WIDTH-1:0] bar
);

  // Window length in cycles, a fraction of one second
  localparam int WINDOW   = CLK_FREQUENCY >> SPEEDUP_FACTOR;
  localparam int WIN_BITS = (WINDOW > 1) ? $clog2(WINDOW) : 1;

  // Index of the final cycle of a window
  localparam logic [WIN_BITS-1:0] WIN_LAST = WIN_BITS'(WINDOW - 1);

  logic [WIN_BITS-1:0]  win_count;
  logic                 win_end;
  rate_t                accumulator;
  rate_t                window_sum;
  rate_t                scaled_sum;
  logic [BAR_WIDTH-1:0] bar_next;

  // ----------------------------------------
  // Window timing and summing
  // ----------------------------------------

  assign win_end = (win_count == WIN_LAST);

  // Includes this cycle's count
  assign window_sum = accumulator + rate_t'(increment);

  // Scale to clusters per second
  assign scaled_sum = window_sum << SPEEDUP_FACTOR;

  always_ff @(posedge clock) begin
    if (reset) begin
      win_count   <= '0;
      accumulator <= '0;
    end else if (win_end) begin
      // Next window starts with the next cycle's count
      win_count   <= '0;
      accumulator <= '0;
    end else begin
      win_count   <= win_count + 1'b1;
      accumulator <= window_sum;
    end
  end

  // ----------------------------------------
  // Thermometer bar
  // ----------------------------------------

  // Bit i lit once the rate reaches (i+1) steps
  // Saturates naturally at the top LED
  always_comb begin
    for (int i = 0; i < BAR_WIDTH; i++) begin
      bar_next[i] = (scaled_sum >= rate_t'((i + 1) * BAR_STEP));
    end
  end

  // ----------------------------------------
  // Result latch
  // ----------------------------------------

  // Rate and bar update together at window end
  always_ff @(posedge clock) begin
    if (reset) begin
      rate <= '0;
      bar  <= '0;
    end else if (win_end) begin
      rate <= scaled_sum;
      bar  <= bar_next;
    end
  end

endmodule

`default_nettype wire

// File: logic/rate_pkg.sv
`default_nettype none

package rate_pkg;

  // Width of the reported cluster rate
  localparam int COUNTER_WIDTH = 32;

  // Width of the per-clock cluster count from the trigger path
  localparam int INCREMENT_WIDTH = 8;

  // Rate word and accumulator type
  typedef logic [COUNTER_WIDTH-1:0] rate_t;

  // Clusters found in one clock
  typedef logic [INCREMENT_WIDTH-1:0] increment_t;

endpackage

`default_nettype wire

// File: logic/led_pkg.sv
`default_nettype none

package led_pkg;

  // Progress bar LEDs on the front panel
  localparam int BAR_WIDTH = 12;

  // Whole panel, bar plus four status LEDs
  localparam int LED_WIDTH = 16;

  // Named view of the panel, MSB first
  typedef struct packed {
    logic                 link_ok;
    logic                 eclk_beat;
    logic                 clk_beat;
    logic                 gbt_flash;
    logic [BAR_WIDTH-1:0] bar;
  } led_fields_t;

  // Same 16 bits seen two ways
  // Raw for the fixed patterns, fields for the status display
  typedef union packed {
    logic [LED_WIDTH-1:0] raw;
    led_fields_t          fields;
  } led_word_u;

endpackage

`default_nettype wire
